// ==== design/cnn_geom_pkg.sv ====
package cnn_geom_pkg;

    // one stored value is a float16 word
    localparam int DATA_WIDTH = 16;

    // kernel slice geometry, one slice is written per commit
    localparam int KERNEL_SIZE_MAX = 3;
    localparam int SLICE_LEN       = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;

    localparam int PARA_Y = 4; // lanes per beat to the compute array

    // weight store
    localparam int WEIGHT_DEPTH      = 256;  // in values
    localparam int WEIGHT_ADDR_WIDTH = 8;
    localparam int BEAT_COUNT_WIDTH  = 8;
    localparam int FM_SIZE_WIDTH     = 4;

    typedef enum logic {
        MODE_CONV = 1'b0,  // lanes strided by one slice
        MODE_FC   = 1'b1   // lanes strided by fm_size squared
    } read_mode_e;

    // one read sequence as launched by the host
    typedef struct packed {
        read_mode_e                   mode;
        logic [WEIGHT_ADDR_WIDTH-1:0] base;
        logic [BEAT_COUNT_WIDTH-1:0]  count;
        logic [FM_SIZE_WIDTH-1:0]     fm_size;
    } read_cmd_t;

    // lane i sits at bits [i*DATA_WIDTH +: DATA_WIDTH], same layout as fp16_pkg::lanes_t
    typedef struct packed {
        logic [PARA_Y-1:0][DATA_WIDTH-1:0] lanes;
        logic                              last;  // final beat of the command
    } weight_beat_t;

endpackage

// ==== design/fp16_pkg.sv ====
package fp16_pkg;

    // raw half precision word, sign in bit 15, 5 bit exponent, 10 bit mantissa
    typedef logic [cnn_geom_pkg::DATA_WIDTH-1:0] fp16_t;

    // a full kernel slice, value 0 in the low bits
    typedef fp16_t [cnn_geom_pkg::SLICE_LEN-1:0] slice_t;

    // one beat worth of values, lane 0 in the low bits
    typedef fp16_t [cnn_geom_pkg::PARA_Y-1:0] lanes_t;

endpackage

// ==== design/wb_weight_regs.sv ====
`timescale 1ns/1ps

module wb_weight_regs #(
    parameter int WEIGHT_ADDR_WIDTH = cnn_geom_pkg::WEIGHT_ADDR_WIDTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [3:0]                     adr,
    input  logic [31:0]                    dat_w,
    input  logic                           busy,
    output logic [31:0]                    dat_r,
    output logic                           ack,
    output logic                           wr_en,
    output logic [WEIGHT_ADDR_WIDTH-1:0]   wr_addr,
    output fp16_pkg::slice_t               wr_slice,
    output logic                           cmd_valid,
    output cnn_geom_pkg::read_cmd_t        cmd
);
    import cnn_geom_pkg::*;
    import fp16_pkg::*;

    // word addresses, words 0 to 4 hold the staged slice
    localparam logic [3:0] ADR_COMMIT = 4'd5;
    localparam logic [3:0] ADR_CMD_A  = 4'd6;
    localparam logic [3:0] ADR_CMD_B  = 4'd7;
    localparam logic [3:0] ADR_STATUS = 4'd8;

    slice_t      stage;        // slice being assembled by the host
    logic        cmd_dropped;  // sticky, launch hit a busy sequencer
    logic        acc;
    logic        wr_acc;
    logic        rd_acc;
    logic        launch;
    logic [31:0] rd_word;

    // classic cycle, accept once and ack on the next edge
    assign acc    = cyc & stb & ~ack;
    assign wr_acc = acc & we;
    assign rd_acc = acc & ~we;
    assign launch = wr_acc & (adr == ADR_CMD_B);

    assign wr_slice = stage;  // committed as a whole at wr_addr

    // read mux, two values per staging word with the low half first
    always_comb begin
        rd_word = '0;
        for (int v = 0; v < SLICE_LEN; v++) begin
            if (adr == 4'(v / 2)) begin
                rd_word[16*(v%2) +: 16] = stage[v];
            end
        end
        if (adr == ADR_STATUS) begin
            rd_word = {30'd0, cmd_dropped, busy};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            dat_r       <= '0;
            wr_en       <= 1'b0;
            cmd_valid   <= 1'b0;
            cmd_dropped <= 1'b0;
        end else begin
            ack       <= acc;
            wr_en     <= wr_acc & (adr == ADR_COMMIT);  // one cycle, lines up with ack
            cmd_valid <= launch & ~busy;
            if (rd_acc) begin
                dat_r <= rd_word;
            end
            if (launch && busy) begin
                cmd_dropped <= 1'b1;
            end else if (rd_acc && adr == ADR_STATUS) begin
                cmd_dropped <= 1'b0; // cleared by reading STATUS
            end
        end
    end

    // staging values, commit address and command fields
    always_ff @(posedge clk) begin
        for (int v = 0; v < SLICE_LEN; v++) begin
            if (wr_acc && adr == 4'(v / 2)) begin
                stage[v] <= (v % 2 == 0) ? dat_w[15:0] : dat_w[31:16];
            end
        end
        if (wr_acc && adr == ADR_COMMIT) begin
            wr_addr <= dat_w[WEIGHT_ADDR_WIDTH-1:0];
        end
        if (wr_acc && adr == ADR_CMD_A) begin
            cmd.base  <= dat_w[7:0];
            cmd.count <= dat_w[15:8];
        end
        if (launch && !busy) begin
            cmd.mode    <= read_mode_e'(dat_w[8]);
            cmd.fm_size <= dat_w[FM_SIZE_WIDTH-1:0];
        end
    end

    // a master that keeps stb high still sees a gap between transfers
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack held high for two cycles");

endmodule

// ==== design/weight_buffer_top.sv ====
`timescale 1ns/1ps

module weight_buffer_top #(
    parameter int KERNEL_SIZE_MAX   = cnn_geom_pkg::KERNEL_SIZE_MAX,
    parameter int PARA_Y            = cnn_geom_pkg::PARA_Y,
    parameter int WEIGHT_DEPTH      = cnn_geom_pkg::WEIGHT_DEPTH,
    parameter int WEIGHT_ADDR_WIDTH = cnn_geom_pkg::WEIGHT_ADDR_WIDTH
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // wishbone classic host port
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [3:0]                  adr,
    input  logic [31:0]                 dat_w,
    output logic [31:0]                 dat_r,
    output logic                        ack,
    // weight stream to the compute array
    output logic                        beat_valid,
    output cnn_geom_pkg::weight_beat_t  beat,
    input  logic                        beat_ready
);
    import cnn_geom_pkg::*;
    import fp16_pkg::*;

    logic                         wr_en;
    logic [WEIGHT_ADDR_WIDTH-1:0] wr_addr;
    slice_t                       wr_slice;
    logic                         cmd_valid;
    read_cmd_t                    cmd;
    logic                         busy;
    logic                         rd_en;
    read_mode_e                   rd_mode;
    logic [WEIGHT_ADDR_WIDTH-1:0] rd_addr;
    logic [FM_SIZE_WIDTH-1:0]     fm_size;
    lanes_t                       rd_lanes;

    wb_weight_regs #(
        .WEIGHT_ADDR_WIDTH (WEIGHT_ADDR_WIDTH)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .busy      (busy),
        .dat_r     (dat_r),
        .ack       (ack),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_slice  (wr_slice),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    weight_read_seq #(
        .WEIGHT_ADDR_WIDTH (WEIGHT_ADDR_WIDTH)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .rd_lanes   (rd_lanes),
        .beat_ready (beat_ready),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_mode    (rd_mode),
        .rd_addr    (rd_addr),
        .fm_size    (fm_size),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    weight_ram_float16 #(
        .KERNEL_SIZE_MAX (KERNEL_SIZE_MAX),
        .PARA_Y          (PARA_Y),
        .WEIGHT_DEPTH    (WEIGHT_DEPTH)
    ) u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_slice (wr_slice),
        .rd_en    (rd_en),
        .rd_mode  (rd_mode),
        .rd_addr  (rd_addr),
        .fm_size  (fm_size),
        .rd_lanes (rd_lanes)
    );

endmodule

// ==== design/weight_ram_float16.sv ====
`timescale 1ns/1ps

module weight_ram_float16 #(
    parameter int KERNEL_SIZE_MAX = cnn_geom_pkg::KERNEL_SIZE_MAX,
    parameter int PARA_Y          = cnn_geom_pkg::PARA_Y,
    parameter int WEIGHT_DEPTH    = cnn_geom_pkg::WEIGHT_DEPTH
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr_en,
    input  logic [$clog2(WEIGHT_DEPTH)-1:0]         wr_addr,
    input  fp16_pkg::slice_t                        wr_slice,
    input  logic                                    rd_en,
    input  cnn_geom_pkg::read_mode_e                rd_mode,
    input  logic [$clog2(WEIGHT_DEPTH)-1:0]         rd_addr,
    input  logic [cnn_geom_pkg::FM_SIZE_WIDTH-1:0]  fm_size,
    output fp16_pkg::lanes_t                        rd_lanes
);
    import cnn_geom_pkg::*;
    import fp16_pkg::*;

    localparam int AW         = $clog2(WEIGHT_DEPTH);
    localparam int SLICE_SIZE = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;
    // wide enough for base plus the largest lane offset before the wrap
    localparam int OFFS_W     = AW + 2 * FM_SIZE_WIDTH + $clog2(SLICE_SIZE + 1)
                                + $clog2(PARA_Y) + 1;

    fp16_t             mem [WEIGHT_DEPTH];
    logic [OFFS_W-1:0] stride;
    logic [AW-1:0]     lane_addr [PARA_Y];
    logic [AW-1:0]     wr_index [SLICE_SIZE];

    // conv lanes step over whole slices, fc lanes over one feature map
    always_comb begin
        if (rd_mode == MODE_FC) begin
            stride = OFFS_W'(fm_size) * OFFS_W'(fm_size);
        end else begin
            stride = OFFS_W'(SLICE_SIZE);
        end
    end

    always_comb begin
        logic [OFFS_W-1:0] sum;
        for (int i = 0; i < PARA_Y; i++) begin
            sum          = OFFS_W'(rd_addr) + OFFS_W'(i) * stride;
            lane_addr[i] = AW'(sum % OFFS_W'(WEIGHT_DEPTH)); // wraps past the top
        end
    end

    always_comb begin
        logic [OFFS_W-1:0] sum;
        for (int j = 0; j < SLICE_SIZE; j++) begin
            sum         = OFFS_W'(wr_addr) + OFFS_W'(j);
            wr_index[j] = AW'(sum % OFFS_W'(WEIGHT_DEPTH));
        end
    end

    // whole slice lands at consecutive addresses in one cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int j = 0; j < SLICE_SIZE; j++) begin
                mem[wr_index[j]] <= wr_slice[j];
            end
        end
    end

    // registered read, output holds while rd_en is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_lanes <= '0;
        end else if (rd_en) begin
            for (int i = 0; i < PARA_Y; i++) begin
                rd_lanes[i] <= mem[lane_addr[i]];
            end
        end
    end

    // the host must place slices so they do not run off the end of the store
    a_slice_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (int'(wr_addr) + SLICE_SIZE <= WEIGHT_DEPTH))
        else $error("slice write at %0d runs past the weight store", wr_addr);

endmodule

// ==== design/weight_read_seq.sv ====
`timescale 1ns/1ps

module weight_read_seq #(
    parameter int WEIGHT_ADDR_WIDTH = cnn_geom_pkg::WEIGHT_ADDR_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cmd_valid,
    input  cnn_geom_pkg::read_cmd_t                 cmd,
    input  fp16_pkg::lanes_t                        rd_lanes,
    input  logic                                    beat_ready,
    output logic                                    busy,
    output logic                                    rd_en,
    output cnn_geom_pkg::read_mode_e                rd_mode,
    output logic [WEIGHT_ADDR_WIDTH-1:0]            rd_addr,
    output logic [cnn_geom_pkg::FM_SIZE_WIDTH-1:0]  fm_size,
    output logic                                    beat_valid,
    output cnn_geom_pkg::weight_beat_t              beat
);
    import cnn_geom_pkg::*;

    read_cmd_t                   cmd_q;      // command being walked
    logic [BEAT_COUNT_WIDTH-1:0] issue_cnt;  // reads sent to the ram
    logic [BEAT_COUNT_WIDTH-1:0] load_cnt;   // beats moved into the output register
    logic                        inflight;   // ram output holds a beat not yet loaded
    logic                        out_free;
    logic                        load;
    logic                        cmd_accept;
    logic                        last_xfer;

    // zero length commands are not taken
    assign cmd_accept = cmd_valid & ~busy & (cmd.count != '0);

    assign out_free  = ~beat_valid | beat_ready;
    assign load      = inflight & out_free;
    assign last_xfer = beat_valid & beat_ready & beat.last;

    // the ram output acts as a skid slot, so a new read only waits when both slots are full
    assign rd_en   = busy & (issue_cnt != cmd_q.count) & (~inflight | out_free);
    assign rd_addr = WEIGHT_ADDR_WIDTH'(cmd_q.base + issue_cnt);
    assign rd_mode = cmd_q.mode;
    assign fm_size = cmd_q.fm_size;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            issue_cnt  <= '0;
            load_cnt   <= '0;
            inflight   <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            if (cmd_accept) begin
                busy      <= 1'b1;
                issue_cnt <= '0;
                load_cnt  <= '0;
            end else begin
                if (last_xfer) begin
                    busy <= 1'b0;  // held until the final beat is taken
                end
                if (rd_en) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (load) begin
                    load_cnt <= load_cnt + 1'b1;
                end
            end
            inflight <= rd_en | (inflight & ~out_free);
            if (load) begin
                beat_valid <= 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_q <= cmd;
        end
        if (load) begin
            beat.lanes <= rd_lanes;
            beat.last  <= (load_cnt == cmd_q.count - 1'b1);
        end
    end

    a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else $error("beat changed while stalled");

    // the register block must filter launches against busy
    a_no_cmd_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |-> !busy)
        else $error("command presented while a read sequence is running");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module weight_buffer_tb --Mdir obj_dir -o weight_buffer_sim

./obj_dir/weight_buffer_sim | tee sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"

// ==== sources.f ====
design/cnn_geom_pkg.sv
design/fp16_pkg.sv
design/wb_weight_regs.sv
design/weight_ram_float16.sv
design/weight_read_seq.sv
design/weight_buffer_top.sv
test/tb_clk_gen.sv
test/weight_buffer_tb.sv

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released away from the active edge
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== test/weight_buffer_tb.sv ====
`timescale 1ns/1ps

module weight_buffer_tb;
    import cnn_geom_pkg::*;

    localparam int TOTAL_BEATS = 104; // sum of all command counts below
    localparam int STEP        = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;
    // 1.0 to 9.0 in half precision
    localparam logic [15:0] UNIT_VALS [9] = '{16'h3c00, 16'h4000, 16'h4200, 16'h4400,
        16'h4500, 16'h4600, 16'h4700, 16'h4800, 16'h4880};

    logic         clk;
    logic         rst_n;
    logic         cyc;
    logic         stb;
    logic         we;
    logic [3:0]   adr;
    logic [31:0]  dat_w;
    logic [31:0]  dat_r;
    logic         ack;
    logic         beat_valid;
    weight_beat_t beat;
    logic         beat_ready;

    logic [15:0]  shadow [WEIGHT_DEPTH]; // model of the weight store
    logic [31:0]  rng_state = 32'hbcc453de;
    int           errors = 0;
    int           checks = 0;
    int           acks_seen = 0;
    int           transfers = 0;
    int           tests_done = 0;

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst_n(rst_n));

    weight_buffer_top #(
        .KERNEL_SIZE_MAX   (KERNEL_SIZE_MAX),
        .PARA_Y            (PARA_Y),
        .WEIGHT_DEPTH      (WEIGHT_DEPTH),
        .WEIGHT_ADDR_WIDTH (WEIGHT_ADDR_WIDTH)
    ) dut (.*);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    always @(negedge clk) begin
        if (rst_n && ack) begin
            acks_seen++; // ack is one cycle wide, so one count per ack
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
        else begin
            $display("** Error at %0t ns: beat changed or vanished under a stall", $time);
            errors++;
        end

    a_beat_known: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid |-> !$isunknown(beat))
        else begin
            $display("** Error at %0t ns: beat carries unknown bits", $time);
            errors++;
        end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wb_access(input logic write, input logic [3:0] a, input logic [31:0] d,
                             output logic [31:0] q);
        int waited;
        waited = 0;
        q = '0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = a;
        dat_w = d;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 16);
        if (ack) begin
            q = dat_r; // registered on the same edge as ack
            transfers++;
        end else begin
            $display("Wishbone access to word %0d was never acknowledged", a);
            errors++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] a, input logic [31:0] d);
        logic [31:0] unused;
        wb_access(1'b1, a, d, unused);
    endtask

    // stage the model values at addr and commit them as one slice
    task automatic commit_slice(input int addr);
        logic [31:0] word;
        for (int w = 0; w < 5; w++) begin
            word[15:0]  = shadow[8'(addr + 2 * w)];
            word[31:16] = (w < 4) ? shadow[8'(addr + 2 * w + 1)] : 16'h0000;
            wb_write(4'(w), word);
        end
        wb_write(4'd5, 32'(addr));
    endtask

    task automatic launch(input logic fc, input int base, input int count, input int fm);
        wb_write(4'd6, {16'd0, 8'(count), 8'(base)});
        wb_write(4'd7, {23'd0, fc, 4'd0, 4'(fm)});
    endtask

    // drives ready and checks each beat at the falling edge before it transfers
    task automatic consume(input logic fc, input int base, input int count, input int fm,
                           input bit stall);
        int          got;
        int          idle;
        int          n;
        int          first_n;
        int          stride;
        logic [31:0] r;
        got     = 0;
        idle    = 0;
        n       = 0;
        first_n = 0;
        stride  = fc ? fm * fm : STEP;
        while (got < count && idle < 200) begin
            @(negedge clk);
            n++;
            r = xorshift32();
            beat_ready = !stall || (r % 5 < 3);
            if (beat_valid && beat_ready) begin
                for (int i = 0; i < PARA_Y; i++) begin
                    check_value("lane value", 32'(beat.lanes[i]),
                                32'(shadow[8'(base + got + i * stride)]));
                end
                check_value("last flag", 32'(beat.last), 32'(got == count - 1));
                if (got == 0) begin
                    first_n = n;
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < count) begin
            $display("stream stopped after %0d of %0d beats", got, count);
            errors++;
        end else if (!stall) begin
            check_value("cycles of a full rate stream", 32'(n - first_n), 32'(count - 1));
        end
        @(negedge clk);
        beat_ready = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("beat_valid after the last beat", 32'(beat_valid), 32'd0);
        end
    endtask

    task automatic run_cmd(input logic fc, input int base, input int count, input int fm,
                           input bit stall);
        logic [31:0] st;
        launch(fc, base, count, fm);
        consume(fc, base, count, fm, stall);
        wb_access(1'b0, 4'd8, 32'd0, st);
        check_value("STATUS after command", st, 32'd0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        @(negedge clk);
        check_value("ack count", 32'(acks_seen), 32'(transfers));
        tests_done++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errors - errs_before);
        end
    endtask

    initial begin
        repeat (200 * TOTAL_BEATS + 4000) @(posedge clk);
        $display("watchdog timeout, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] words [5];
        logic [31:0] rd;
        logic [31:0] r;
        int          addr;
        int          errs0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        beat_ready = 1'b0;
        @(posedge rst_n);

        errs0 = errors;
        for (int w = 0; w < 5; w++) begin
            words[w] = xorshift32();
            wb_write(4'(w), words[w]);
        end
        for (int w = 0; w < 5; w++) begin
            wb_access(1'b0, 4'(w), 32'd0, rd);
            check_value("staging word", rd, (w == 4) ? {16'h0000, words[w][15:0]} : words[w]);
        end
        wb_access(1'b0, 4'd8, 32'd0, rd);
        check_value("idle STATUS", rd, 32'd0);
        wb_access(1'b0, 4'd12, 32'd0, rd);
        check_value("unmapped word", rd, 32'd0);
        finish_test("register access", errs0);

        // two fixed 3x3 slices, then random ones, the last slice ends at the top
        errs0 = errors;
        for (int s = 0; s < 29; s++) begin
            addr = (s == 28) ? WEIGHT_DEPTH - STEP : s * STEP;
            for (int j = 0; j < STEP; j++) begin
                r = xorshift32();
                if (s < 2) begin
                    r[15:0] = UNIT_VALS[j] | (s == 1 ? 16'h8000 : 16'h0000);
                end
                shadow[8'(addr + j)] = r[15:0];
            end
            commit_slice(addr);
        end
        run_cmd(1'b0, 0, 24, 0, 1'b0);
        finish_test("conv stride", errs0);

        errs0 = errors;
        run_cmd(1'b1, 100, 16, 3, 1'b0);
        run_cmd(1'b1, 240, 8, 2, 1'b0); // lanes wrap past the top of the store
        finish_test("fc stride", errs0);

        errs0 = errors;
        run_cmd(1'b0, 200, 40, 0, 1'b1);
        finish_test("random stalls", errs0);

        errs0 = errors;
        launch(1'b1, 30, 16, 4);
        fork
            consume(1'b1, 30, 16, 4, 1'b1);
            begin
                repeat (3) @(negedge clk);
                wb_write(4'd7, 32'h0000_0001);
                wb_access(1'b0, 4'd8, 32'd0, rd);
                check_value("STATUS with dropped launch", rd, 32'd3);
                wb_access(1'b0, 4'd8, 32'd0, rd);
                check_value("cmd_dropped after STATUS read", 32'(rd[1]), 32'd0);
            end
        join
        wb_access(1'b0, 4'd8, 32'd0, rd);
        check_value("STATUS after command", rd, 32'd0);
        finish_test("dropped launch", errs0);

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
